/* sim.f */
vp_pkg.sv
vp_frontend.sv
vp_vrf.sv
vp_vector_alu.sv
vp_bypass.sv
vp_core.sv
tb_vp_core.sv

/* tb_vp_core.sv */
module tb_vp_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN = 17;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 4 + 100;

    logic                            clk;
    logic                            rst_n = 1'b0;
    logic                            en;
    logic [vp_pkg::PC_WIDTH-1:0]     pc;
    logic [vp_pkg::INSTR_WIDTH-1:0]  instr;
    logic [vp_pkg::MEM_ADDR_WIDTH-1:0] mem_addr;
    logic                            mem_ren;
    logic                            mem_we;
    vp_pkg::vec_t                    mem_rdata = '0;
    vp_pkg::vec_t                    mem_wdata;
    logic                            data_out_vld;
    vp_pkg::vec_t                    data_out;
    vp_pkg::reg_addr_t               reg_wb;

    int seed = 83181;
    int value_errs = 0;
    int other_errs = 0;

    logic [31:0]       rom [256];
    vp_pkg::vec_t      init_mem [256];
    vp_pkg::vec_t      dmem [256];

    // expected write-backs and stores, in program order
    vp_pkg::reg_addr_t exp_vd [64];
    vp_pkg::vec_t      exp_val [64];
    logic [7:0]        exp_st_addr [16];
    vp_pkg::vec_t      exp_st_data [16];
    int exp_n = 0;
    int st_n = 0;
    int wb_idx = 0;
    int st_idx = 0;

    vp_pkg::reg_addr_t head_vd;
    vp_pkg::vec_t      head_val;
    logic [7:0]        head_st_addr;
    vp_pkg::vec_t      head_st_data;

    vp_core #(
        .LANES      (vp_pkg::LANES     ),
        .ELEM_WIDTH (vp_pkg::ELEM_WIDTH)
    ) dut0 (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .en           (en          ),
        .pc           (pc          ),
        .instr        (instr       ),
        .mem_addr     (mem_addr    ),
        .mem_ren      (mem_ren     ),
        .mem_we       (mem_we      ),
        .mem_rdata    (mem_rdata   ),
        .mem_wdata    (mem_wdata   ),
        .data_out_vld (data_out_vld),
        .data_out     (data_out    ),
        .reg_wb       (reg_wb      )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================================================================
    // instruction ROM and data memory
    // ====================================================================

    assign instr = rom[pc];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= init_mem[a];
            end
        end else begin
            if (mem_we) begin
                dmem[mem_addr] <= mem_wdata;
            end
            // read data held until the next read
            if (mem_ren) begin
                mem_rdata <= dmem[mem_addr];
            end
        end
    end

    function automatic logic [31:0] encode(input logic [3:0] op, input int vd, input int vs1,
                                           input int vs2, input int imm);
        logic [31:0] w;
        w = '0;
        w[31:28] = op;
        w[27:23] = vd[4:0];
        w[22:18] = vs1[4:0];
        w[17:13] = vs2[4:0];
        w[7:0]   = imm[7:0];
        return w;
    endfunction

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            rom[a] = '0;
        end
        rom[0]  = encode(vp_pkg::OP_VLD,  1, 0, 0, 3);
        rom[1]  = encode(vp_pkg::OP_VLD,  2, 0, 0, 7);
        // load-use on v2, v1 through the write-first file
        rom[2]  = encode(vp_pkg::OP_VADD, 3, 1, 2, 0);
        rom[3]  = encode(vp_pkg::OP_VSUB, 4, 3, 1, 0);
        rom[4]  = encode(vp_pkg::OP_VAND, 5, 4, 3, 0);
        rom[5]  = encode(vp_pkg::OP_VOR,  6, 5, 2, 0);
        // v4 at distance 3
        rom[6]  = encode(vp_pkg::OP_VXOR, 7, 6, 4, 0);
        rom[7]  = encode(vp_pkg::OP_VSLL, 8, 7, 0, 5);
        rom[8]  = encode(vp_pkg::OP_VADD, 9, 8, 1, 0);
        rom[9]  = encode(vp_pkg::OP_VST,  0, 0, 9, 200);
        rom[10] = encode(vp_pkg::OP_VLD,  10, 0, 0, 200);
        rom[11] = encode(vp_pkg::OP_VXOR, 11, 10, 1, 0);
        rom[12] = encode(vp_pkg::OP_JMP,  0, 0, 0, 14);
        rom[13] = encode(vp_pkg::OP_VADD, 12, 1, 1, 0);
        rom[14] = encode(vp_pkg::OP_VST,  0, 0, 11, 201);
        rom[15] = encode(vp_pkg::OP_NOP,  0, 0, 0, 0);
        rom[16] = encode(vp_pkg::OP_JMP,  0, 0, 0, 16);
    endtask

    // ====================================================================
    // reference model
    // ====================================================================

    function automatic vp_pkg::vec_t lane_op(input logic [3:0] op, input vp_pkg::vec_t a,
                                             input vp_pkg::vec_t b, input logic [7:0] imm);
        vp_pkg::vec_t r;
        for (int l = 0; l < vp_pkg::LANES; l++) begin
            case (op)
                vp_pkg::OP_VADD: r[l] = a[l] + b[l];
                vp_pkg::OP_VSUB: r[l] = a[l] - b[l];
                vp_pkg::OP_VAND: r[l] = a[l] & b[l];
                vp_pkg::OP_VOR:  r[l] = a[l] | b[l];
                vp_pkg::OP_VXOR: r[l] = a[l] ^ b[l];
                vp_pkg::OP_VSLL: r[l] = a[l] << imm[3:0];
                default:         r[l] = '0;
            endcase
        end
        return r;
    endfunction

    // walks the program in order until the jump to itself
    task automatic build_model();
        vp_pkg::vec_t regs [32];
        vp_pkg::vec_t mem [256];
        logic [31:0]  w;
        logic [3:0]   op;
        logic [7:0]   imm;
        int           pc_m;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            mem[a] = init_mem[a];
        end
        pc_m = 0;
        for (int step = 0; step < 256; step++) begin
            w = rom[pc_m];
            op = w[31:28];
            imm = w[7:0];
            if (op == vp_pkg::OP_JMP && imm == pc_m) begin
                break;
            end
            if (op >= vp_pkg::OP_VADD && op <= vp_pkg::OP_VSLL) begin
                regs[w[27:23]] = lane_op(op, regs[w[22:18]], regs[w[17:13]], imm);
            end else if (op == vp_pkg::OP_VLD) begin
                regs[w[27:23]] = mem[imm];
            end else if (op == vp_pkg::OP_VST) begin
                mem[imm] = regs[w[17:13]];
                exp_st_addr[st_n] = imm;
                exp_st_data[st_n] = regs[w[17:13]];
                st_n++;
            end
            if (op >= vp_pkg::OP_VADD && op <= vp_pkg::OP_VLD) begin
                exp_vd[exp_n] = w[27:23];
                exp_val[exp_n] = regs[w[27:23]];
                exp_n++;
            end
            pc_m = (op == vp_pkg::OP_JMP) ? imm : pc_m + 1;
        end
    endtask

    // ====================================================================
    // checks
    // ====================================================================

    assign head_vd      = exp_vd[wb_idx];
    assign head_val     = exp_val[wb_idx];
    assign head_st_addr = exp_st_addr[st_idx];
    assign head_st_data = exp_st_data[st_idx];

    always @(posedge clk) begin
        if (rst_n && data_out_vld) begin
            wb_idx <= wb_idx + 1;
        end
        if (rst_n && mem_we) begin
            st_idx <= st_idx + 1;
        end
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (pc == 0) && !data_out_vld && !mem_ren && !mem_we)
        else begin
            other_errs++;
            $display("pc or a strobe was not cleared by reset");
        end

    wb_extra: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_vld |-> (wb_idx < exp_n))
        else begin
            other_errs++;
            $display("write-back pulse beyond the expected %0d", exp_n);
        end

    wb_value: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_vld |-> (reg_wb == head_vd) && (data_out == head_val))
        else begin
            value_errs++;
            $display("Mismatch wb_value: expected v%0d %h, actual v%0d %h",
                     $sampled(head_vd), $sampled(head_val), $sampled(reg_wb),
                     $sampled(data_out));
        end

    st_extra: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> (st_idx < st_n))
        else begin
            other_errs++;
            $display("store issued beyond the expected %0d", st_n);
        end

    st_value: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> (mem_addr == head_st_addr) && (mem_wdata == head_st_data))
        else begin
            value_errs++;
            $display("Mismatch st_value: expected [%0d] %h, actual [%0d] %h",
                     $sampled(head_st_addr), $sampled(head_st_data),
                     $sampled(mem_addr), $sampled(mem_wdata));
        end

    idle_strobes: assert property (@(posedge clk) disable iff (!rst_n)
        !en |-> !mem_ren && !mem_we && !data_out_vld)
        else begin
            other_errs++;
            $display("strobe active while en was low");
        end

    idle_pc: assert property (@(posedge clk) disable iff (!rst_n)
        !en |=> $stable(pc))
        else begin
            other_errs++;
            $display("pc moved while en was low");
        end

    // ====================================================================
    // stimulus
    // ====================================================================

    // random stretches of en low once out of reset
    initial begin : en_driver
        int gap;
        int len;
        en = 1'b1;
        @(posedge rst_n);
        repeat (4) begin
            gap = 3 + ($random(seed) & 7);
            len = 1 + ($random(seed) & 3);
            repeat (gap) @(negedge clk);
            en = 1'b0;
            repeat (len) @(negedge clk);
            en = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d write-backs and %0d of %0d stores seen",
                 WATCHDOG_CYCLES, wb_idx, exp_n, st_idx, st_n);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        for (int a = 0; a < 256; a++) begin
            init_mem[a] = {$random(seed), $random(seed)};
        end
        load_program();
        build_model();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait (wb_idx == exp_n && st_idx == st_n);
        // catch stray pulses from the final jump loop
        repeat (10) @(negedge clk);
        assert (wb_idx == exp_n && st_idx == st_n)
        else begin
            other_errs++;
            $display("event count wrong, %0d write-backs and %0d stores", wb_idx, st_idx);
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vp_bypass.sv */
module vp_bypass #(
    parameter int LANES      = vp_pkg::LANES,
    parameter int ELEM_WIDTH = vp_pkg::ELEM_WIDTH
) (
    input  vp_pkg::reg_addr_t                src,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] rf_data,

    input  logic                             ex2_we,
    input  vp_pkg::reg_addr_t                ex2_vd,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] ex2_data,

    input  logic                             wb_we,
    input  vp_pkg::reg_addr_t                wb_vd,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] wb_data,

    output logic [LANES-1:0][ELEM_WIDTH-1:0] operand
);

    logic ex2_hit;
    logic wb_hit;

    assign ex2_hit = ex2_we && (ex2_vd == src);
    assign wb_hit  = wb_we && (wb_vd == src);

    // youngest producer wins
    always_comb begin
        if (ex2_hit) begin
            operand = ex2_data;
        end else if (wb_hit) begin
            operand = wb_data;
        end else begin
            operand = rf_data;
        end
    end

endmodule

/* vp_core.sv */
module vp_core #(
    parameter int LANES      = vp_pkg::LANES,
    parameter int ELEM_WIDTH = vp_pkg::ELEM_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                en,

    output logic [vp_pkg::PC_WIDTH-1:0]         pc,
    input  logic [vp_pkg::INSTR_WIDTH-1:0]      instr,

    output logic [vp_pkg::MEM_ADDR_WIDTH-1:0]   mem_addr,
    output logic                                mem_ren,
    output logic                                mem_we,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0]    mem_rdata,
    output logic [LANES-1:0][ELEM_WIDTH-1:0]    mem_wdata,

    output logic                                data_out_vld,
    output logic [LANES-1:0][ELEM_WIDTH-1:0]    data_out,
    output vp_pkg::reg_addr_t                   reg_wb
);

    // ID
    vp_pkg::reg_addr_t                id_vd;
    vp_pkg::reg_addr_t                id_vs1;
    vp_pkg::reg_addr_t                id_vs2;
    logic [vp_pkg::IMM_WIDTH-1:0]     id_imm;
    vp_pkg::alu_op_t                  id_alu_op;
    logic                             id_reg_we;
    logic                             id_is_load;
    logic                             id_is_store;
    logic [LANES-1:0][ELEM_WIDTH-1:0] id_rs1_data;
    logic [LANES-1:0][ELEM_WIDTH-1:0] id_rs2_data;

    // EX1
    logic                             ex1_reg_we;
    logic                             ex1_load;
    logic                             ex1_store;
    vp_pkg::reg_addr_t                ex1_vd;
    vp_pkg::reg_addr_t                ex1_vs1;
    vp_pkg::reg_addr_t                ex1_vs2;
    logic [vp_pkg::IMM_WIDTH-1:0]     ex1_imm;
    vp_pkg::alu_op_t                  ex1_alu_op;
    logic [LANES-1:0][ELEM_WIDTH-1:0] ex1_rs1_data;
    logic [LANES-1:0][ELEM_WIDTH-1:0] ex1_rs2_data;
    logic [LANES-1:0][ELEM_WIDTH-1:0] operand_a;
    logic [LANES-1:0][ELEM_WIDTH-1:0] operand_b;
    logic [LANES-1:0][ELEM_WIDTH-1:0] alu_out;

    // EX2 and WB
    logic                             ex2_reg_we;
    logic                             ex2_load;
    vp_pkg::reg_addr_t                ex2_vd;
    logic [LANES-1:0][ELEM_WIDTH-1:0] ex2_alu;
    logic                             wb_reg_we;
    logic                             wb_load;
    vp_pkg::reg_addr_t                wb_vd;
    logic [LANES-1:0][ELEM_WIDTH-1:0] wb_alu;
    logic [LANES-1:0][ELEM_WIDTH-1:0] wb_mem;
    logic [LANES-1:0][ELEM_WIDTH-1:0] wb_data;

    // ====================================================================
    // fetch / decode
    // ====================================================================

    vp_frontend frontend_inst (
        .clk      (clk        ),
        .rst_n    (rst_n      ),
        .en       (en         ),
        .instr    (instr      ),
        .ex1_load (ex1_load   ),
        .ex1_vd   (ex1_vd     ),
        .pc       (pc         ),
        .vd       (id_vd      ),
        .vs1      (id_vs1     ),
        .vs2      (id_vs2     ),
        .imm      (id_imm     ),
        .alu_op   (id_alu_op  ),
        .reg_we   (id_reg_we  ),
        .is_load  (id_is_load ),
        .is_store (id_is_store),
        .stall    (           )
    );

    vp_vrf #(
        .LANES      (LANES          ),
        .ELEM_WIDTH (ELEM_WIDTH     ),
        .NUM_REGS   (vp_pkg::NUM_REGS)
    ) vrf_inst (
        .clk    (clk             ),
        .rst_n  (rst_n           ),
        .we     (en && wb_reg_we ),
        .waddr  (wb_vd           ),
        .wdata  (wb_data         ),
        .raddr1 (id_vs1          ),
        .raddr2 (id_vs2          ),
        .rdata1 (id_rs1_data     ),
        .rdata2 (id_rs2_data     )
    );

    // ====================================================================
    // execute
    // ====================================================================

    // loads have no EX2 path because the stall covers that distance
    vp_bypass #(
        .LANES      (LANES     ),
        .ELEM_WIDTH (ELEM_WIDTH)
    ) bypass_a_inst (
        .src      (ex1_vs1                ),
        .rf_data  (ex1_rs1_data           ),
        .ex2_we   (ex2_reg_we && !ex2_load),
        .ex2_vd   (ex2_vd                 ),
        .ex2_data (ex2_alu                ),
        .wb_we    (wb_reg_we              ),
        .wb_vd    (wb_vd                  ),
        .wb_data  (wb_data                ),
        .operand  (operand_a              )
    );

    vp_bypass #(
        .LANES      (LANES     ),
        .ELEM_WIDTH (ELEM_WIDTH)
    ) bypass_b_inst (
        .src      (ex1_vs2                ),
        .rf_data  (ex1_rs2_data           ),
        .ex2_we   (ex2_reg_we && !ex2_load),
        .ex2_vd   (ex2_vd                 ),
        .ex2_data (ex2_alu                ),
        .wb_we    (wb_reg_we              ),
        .wb_vd    (wb_vd                  ),
        .wb_data  (wb_data                ),
        .operand  (operand_b              )
    );

    vp_vector_alu #(
        .LANES      (LANES     ),
        .ELEM_WIDTH (ELEM_WIDTH)
    ) alu_inst (
        .op      (ex1_alu_op   ),
        .vec_a   (operand_a    ),
        .vec_b   (operand_b    ),
        .shamt   (ex1_imm[3:0] ),
        .vec_out (alu_out      )
    );

    // ====================================================================
    // memory port and write-back
    // ====================================================================

    // store data is vs2 after forwarding
    assign mem_addr  = ex1_imm;
    assign mem_ren   = en && ex1_load;
    assign mem_we    = en && ex1_store;
    assign mem_wdata = operand_b;

    assign wb_data      = wb_load ? wb_mem : wb_alu;
    assign data_out     = wb_data;
    assign data_out_vld = en && wb_reg_we;
    assign reg_wb       = wb_vd;

    // ====================================================================
    // pipeline registers
    // ====================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex1_reg_we <= 1'b0;
            ex1_load   <= 1'b0;
            ex1_store  <= 1'b0;
            ex2_reg_we <= 1'b0;
            ex2_load   <= 1'b0;
            wb_reg_we  <= 1'b0;
            wb_load    <= 1'b0;
        end else if (en) begin
            ex1_reg_we <= id_reg_we;
            ex1_load   <= id_is_load;
            ex1_store  <= id_is_store;
            ex2_reg_we <= ex1_reg_we;
            ex2_load   <= ex1_load;
            wb_reg_we  <= ex2_reg_we;
            wb_load    <= ex2_load;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            ex1_vd       <= id_vd;
            ex1_vs1      <= id_vs1;
            ex1_vs2      <= id_vs2;
            ex1_imm      <= id_imm;
            ex1_alu_op   <= id_alu_op;
            ex1_rs1_data <= id_rs1_data;
            ex1_rs2_data <= id_rs2_data;
            ex2_vd       <= ex1_vd;
            ex2_alu      <= alu_out;
            wb_vd        <= ex2_vd;
            wb_alu       <= ex2_alu;
            // read data arrives while the load sits in EX2
            wb_mem       <= mem_rdata;
        end
    end

    mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_ren && mem_we)
    );

endmodule

/* vp_frontend.sv */
module vp_frontend (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           en,
    input  logic [vp_pkg::INSTR_WIDTH-1:0] instr,

    input  logic                           ex1_load,
    input  vp_pkg::reg_addr_t              ex1_vd,

    output logic [vp_pkg::PC_WIDTH-1:0]    pc,
    output vp_pkg::reg_addr_t              vd,
    output vp_pkg::reg_addr_t              vs1,
    output vp_pkg::reg_addr_t              vs2,
    output logic [vp_pkg::IMM_WIDTH-1:0]   imm,
    output vp_pkg::alu_op_t                alu_op,
    output logic                           reg_we,
    output logic                           is_load,
    output logic                           is_store,
    output logic                           stall
);

    vp_pkg::opcode_t opcode;
    logic            dec_alu;
    logic            dec_load;
    logic            dec_store;
    logic            dec_jmp;
    logic            reads_vs1;
    logic            reads_vs2;
    logic            vs1_hit;
    logic            vs2_hit;

    // ====================================================================
    // field extraction
    // ====================================================================

    assign opcode = vp_pkg::opcode_t'(instr[vp_pkg::OPCODE_MSB -: $bits(vp_pkg::opcode_t)]);
    assign vd     = instr[vp_pkg::VD_LSB  +: vp_pkg::REG_ADDR_WIDTH];
    assign vs1    = instr[vp_pkg::VS1_LSB +: vp_pkg::REG_ADDR_WIDTH];
    assign vs2    = instr[vp_pkg::VS2_LSB +: vp_pkg::REG_ADDR_WIDTH];
    assign imm    = instr[vp_pkg::IMM_WIDTH-1:0];

    // ====================================================================
    // control decode
    // ====================================================================

    always_comb begin
        dec_alu   = 1'b0;
        dec_load  = 1'b0;
        dec_store = 1'b0;
        dec_jmp   = 1'b0;
        reads_vs1 = 1'b0;
        reads_vs2 = 1'b0;
        alu_op    = vp_pkg::ALU_ADD;
        case (opcode)
            vp_pkg::OP_VADD,
            vp_pkg::OP_VSUB,
            vp_pkg::OP_VAND,
            vp_pkg::OP_VOR,
            vp_pkg::OP_VXOR: begin
                dec_alu   = 1'b1;
                reads_vs1 = 1'b1;
                reads_vs2 = 1'b1;
            end
            vp_pkg::OP_VSLL: begin
                // shift amount comes from imm, vs2 unused
                dec_alu   = 1'b1;
                reads_vs1 = 1'b1;
            end
            vp_pkg::OP_VLD: begin
                dec_load = 1'b1;
            end
            vp_pkg::OP_VST: begin
                dec_store = 1'b1;
                reads_vs2 = 1'b1;
            end
            vp_pkg::OP_JMP: begin
                dec_jmp = 1'b1;
            end
            default: begin
            end
        endcase

        case (opcode)
            vp_pkg::OP_VSUB: alu_op = vp_pkg::ALU_SUB;
            vp_pkg::OP_VAND: alu_op = vp_pkg::ALU_AND;
            vp_pkg::OP_VOR:  alu_op = vp_pkg::ALU_OR;
            vp_pkg::OP_VXOR: alu_op = vp_pkg::ALU_XOR;
            vp_pkg::OP_VSLL: alu_op = vp_pkg::ALU_SLL;
            default:         alu_op = vp_pkg::ALU_ADD;
        endcase
    end

    // ====================================================================
    // load-use hazard
    // ====================================================================

    assign vs1_hit = reads_vs1 && (vs1 == ex1_vd);
    assign vs2_hit = reads_vs2 && (vs2 == ex1_vd);
    assign stall   = ex1_load && (vs1_hit || vs2_hit);

    // flags as they enter EX1, a stall turns them into a bubble
    assign reg_we   = (dec_alu || dec_load) && !stall;
    assign is_load  = dec_load && !stall;
    assign is_store = dec_store && !stall;

    // ====================================================================
    // program counter
    // ====================================================================

    // jump resolves in ID so nothing from the wrong path is fetched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en && !stall) begin
            if (dec_jmp) begin
                pc <= imm;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    stall_needs_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> ex1_load
    );

    // the bubble left in EX1 clears the hazard on the next enabled edge
    stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && en) |=> !stall
    );

endmodule

/* vp_pkg.sv */
package vp_pkg;

    // ====================================================================
    // widths
    // ====================================================================

    localparam int LANES          = 4;
    localparam int ELEM_WIDTH     = 16;
    localparam int VEC_WIDTH      = LANES * ELEM_WIDTH;
    localparam int NUM_REGS       = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int PC_WIDTH       = 8;
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int INSTR_WIDTH    = 32;

    // ====================================================================
    // instruction fields
    // ====================================================================

    // opcode sits in the top nibble
    localparam int OPCODE_MSB = 31;
    localparam int VD_LSB     = 23;
    localparam int VS1_LSB    = 18;
    localparam int VS2_LSB    = 13;
    // imm starts at bit 0
    localparam int IMM_WIDTH  = 8;

    // ====================================================================
    // types
    // ====================================================================

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_VADD = 4'd1,
        OP_VSUB = 4'd2,
        OP_VAND = 4'd3,
        OP_VOR  = 4'd4,
        OP_VXOR = 4'd5,
        OP_VSLL = 4'd6,
        OP_VLD  = 4'd7,
        OP_VST  = 4'd8,
        OP_JMP  = 4'd9
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_t;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // lane 0 in the low bits
    typedef logic [LANES-1:0][ELEM_WIDTH-1:0] vec_t;

endpackage

/* vp_vector_alu.sv */
module vp_vector_alu #(
    parameter int LANES      = vp_pkg::LANES,
    parameter int ELEM_WIDTH = vp_pkg::ELEM_WIDTH
) (
    input  vp_pkg::alu_op_t                  op,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] vec_a,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] vec_b,
    input  logic [3:0]                       shamt,
    output logic [LANES-1:0][ELEM_WIDTH-1:0] vec_out
);

    // ====================================================================
    // one slice per lane, no carries between lanes
    // ====================================================================

    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
        logic [ELEM_WIDTH-1:0] a;
        logic [ELEM_WIDTH-1:0] b;
        logic [ELEM_WIDTH-1:0] res;

        assign a = vec_a[lane];
        assign b = vec_b[lane];

        // results truncate to lane width, so add and sub wrap
        always_comb begin
            case (op)
                vp_pkg::ALU_ADD: begin
                    res = a + b;
                end
                vp_pkg::ALU_SUB: begin
                    res = a - b;
                end
                vp_pkg::ALU_AND: begin
                    res = a & b;
                end
                vp_pkg::ALU_OR: begin
                    res = a | b;
                end
                vp_pkg::ALU_XOR: begin
                    res = a ^ b;
                end
                vp_pkg::ALU_SLL: begin
                    res = a << shamt;
                end
                default: begin
                    res = '0;
                end
            endcase
        end

        assign vec_out[lane] = res;
    end

endmodule

/* vp_vrf.sv */
module vp_vrf #(
    parameter int LANES      = vp_pkg::LANES,
    parameter int ELEM_WIDTH = vp_pkg::ELEM_WIDTH,
    parameter int NUM_REGS   = vp_pkg::NUM_REGS
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             we,
    input  vp_pkg::reg_addr_t                waddr,
    input  logic [LANES-1:0][ELEM_WIDTH-1:0] wdata,

    input  vp_pkg::reg_addr_t                raddr1,
    input  vp_pkg::reg_addr_t                raddr2,
    output logic [LANES-1:0][ELEM_WIDTH-1:0] rdata1,
    output logic [LANES-1:0][ELEM_WIDTH-1:0] rdata2
);

    logic [LANES-1:0][ELEM_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-first, same-cycle write shows up on the read port
    assign rdata1 = (we && (waddr == raddr1)) ? wdata : regs[raddr1];
    assign rdata2 = (we && (waddr == raddr2)) ? wdata : regs[raddr2];

    // write-back destinations come from decode three stages earlier
    waddr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> (waddr < NUM_REGS)
    );

endmodule
